//--- bbox_settings.svh
// Global sizing for the bounding-box stage.
// Coordinates are signed fixed point with BBOX_RADIX fraction bits.
// BBOX_PIPE_DEPTH must be at least 1.
// The subsample decoder assumes a 4-bit one-hot code.

`ifndef BBOX_SETTINGS_SVH
`define BBOX_SETTINGS_SVH

// total coordinate width in bits
`define BBOX_SIGFIG 24

// fraction bits at the bottom of each coordinate
`define BBOX_RADIX 10

// integer bits including sign
`define BBOX_INT_BITS (`BBOX_SIGFIG - `BBOX_RADIX)

// registers between input and output
`define BBOX_PIPE_DEPTH 3

// width of the one-hot subsample code
`define BBOX_SS_BITS 4

`endif

//--- bbox_pkg.sv
// Shared types for the bounding-box stage.
// All coordinates are two's complement fixed point.
// Vertex order in tri_t is index 0 to 2, winding decides facing.

`include "bbox_settings.svh"

package bbox_pkg;

    // vertices per triangle
    localparam int NUM_VERTS = 3;

    // integer and fraction split of a coordinate
    typedef struct packed {
        logic signed [`BBOX_INT_BITS-1:0] ipart;
        logic [`BBOX_RADIX-1:0]           frac;
    } coord_fields_t;

    // same word read as one signed value or as its fixed-point fields
    typedef union packed {
        logic signed [`BBOX_SIGFIG-1:0] whole;
        coord_fields_t                  fixed;
    } coord_u;

    typedef struct packed {
        coord_u x;
        coord_u y;
    } vertex_t;

    typedef vertex_t [NUM_VERTS-1:0] tri_t;

    // ll is the min corner, ur the max corner
    typedef struct packed {
        vertex_t ll;
        vertex_t ur;
    } box_t;

    // screen extent in the same fixed-point format
    typedef struct packed {
        coord_u width;
        coord_u height;
    } screen_t;

    // one-hot, msb is 1x and lsb is 64x
    typedef logic [`BBOX_SS_BITS-1:0] ss_code_t;

    // word carried down the delay line
    typedef struct packed {
        logic    valid;
        tri_t    tri_data;
        box_t    box;
    } bbox_item_t;

endpackage

//--- bbox_extent.sv
// Raw bounding box of one triangle, purely combinational.
// Corners come straight from vertex coordinates, no rounding here.

`timescale 1ns/1ps

module bbox_extent (
    input  bbox_pkg::tri_t tri_in,
    output bbox_pkg::box_t box
);

    // seed both corners with vertex 0, then sweep the rest
    always_comb begin
        box.ll = tri_in[0];
        box.ur = tri_in[0];
        for (int i = 1; i < bbox_pkg::NUM_VERTS; i++) begin
            // lower-left x tracks the minimum
            if (tri_in[i].x.whole < box.ll.x.whole) begin
                box.ll.x = tri_in[i].x;
            end
            // lower-left y tracks the minimum
            if (tri_in[i].y.whole < box.ll.y.whole) begin
                box.ll.y = tri_in[i].y;
            end
            // upper-right x tracks the maximum
            if (tri_in[i].x.whole > box.ur.x.whole) begin
                box.ur.x = tri_in[i].x;
            end
            // upper-right y tracks the maximum
            if (tri_in[i].y.whole > box.ur.y.whole) begin
                box.ur.y = tri_in[i].y;
            end
        end
    end

endmodule

//--- bbox_snap.sv
// Floors every box corner onto the subsample grid.
// Clearing low fraction bits floors toward minus infinity,
// so negative corners move further negative.
// Codes other than the four one-hot values act as 1x.

`timescale 1ns/1ps
`include "bbox_settings.svh"

module bbox_snap (
    input  bbox_pkg::box_t     box_in,
    input  bbox_pkg::ss_code_t ss_code,
    output bbox_pkg::box_t     box_out
);

    // fraction bits kept, log2 of samples per pixel side
    logic [1:0]             keep_bits;
    // ones over the kept fraction bits
    logic [`BBOX_RADIX-1:0] frac_mask;

    // integer field passes, fraction field is masked
    function automatic bbox_pkg::coord_u snap_coord(
        input bbox_pkg::coord_u       c,
        input logic [`BBOX_RADIX-1:0] mask
    );
        bbox_pkg::coord_u r;
        r.fixed.ipart = c.fixed.ipart;
        r.fixed.frac  = c.fixed.frac & mask;
        return r;
    endfunction

    always_comb begin
        case (ss_code)
            4'b1000: keep_bits = 2'd0;
            // half-pixel samples
            4'b0100: keep_bits = 2'd1;
            // quarter-pixel samples
            4'b0010: keep_bits = 2'd2;
            // eighth-pixel samples
            4'b0001: keep_bits = 2'd3;
            default: keep_bits = 2'd0;
        endcase
        // 1x gives an all-zero mask, whole pixels only
        frac_mask = ~({`BBOX_RADIX{1'b1}} >> keep_bits);
    end

    assign box_out.ll.x = snap_coord(box_in.ll.x, frac_mask);
    assign box_out.ll.y = snap_coord(box_in.ll.y, frac_mask);
    assign box_out.ur.x = snap_coord(box_in.ur.x, frac_mask);
    assign box_out.ur.y = snap_coord(box_in.ur.y, frac_mask);

endmodule

//--- bbox_clip.sv
// Screen clamp and back-face cull, combinational.
// Each edge is clamped on its own; a box fully off screen is not rejected.
// The screen size is assumed non-negative and held steady.
// Back-face products are exact, 2*(SIGFIG+1) bits.

`timescale 1ns/1ps
`include "bbox_settings.svh"

module bbox_clip (
    input  bbox_pkg::tri_t       tri_in,
    input  logic                 tri_valid,
    input  bbox_pkg::box_t       box_in,
    input  bbox_pkg::screen_t    screen,
    output bbox_pkg::bbox_item_t item
);

    // one guard bit for a difference, double that for a product
    localparam int DIFF_W  = `BBOX_SIGFIG + 1;
    localparam int CROSS_W = 2 * DIFF_W;

    // edge differences, one bit wider than a coordinate
    logic signed [`BBOX_SIGFIG:0]       dx10;
    logic signed [`BBOX_SIGFIG:0]       dy21;
    logic signed [`BBOX_SIGFIG:0]       dy10;
    logic signed [`BBOX_SIGFIG:0]       dx21;
    // cross-product terms
    logic signed [2*`BBOX_SIGFIG+1:0]   cross_lhs;
    logic signed [2*`BBOX_SIGFIG+1:0]   cross_rhs;
    logic                               back_face;
    bbox_pkg::box_t                     box_clip;

    // coordinates sign-extend by one bit so no difference overflows
    assign dx10 = DIFF_W'(tri_in[1].x.whole) - DIFF_W'(tri_in[0].x.whole);
    assign dy21 = DIFF_W'(tri_in[2].y.whole) - DIFF_W'(tri_in[1].y.whole);
    assign dy10 = DIFF_W'(tri_in[1].y.whole) - DIFF_W'(tri_in[0].y.whole);
    assign dx21 = DIFF_W'(tri_in[2].x.whole) - DIFF_W'(tri_in[1].x.whole);

    assign cross_lhs = CROSS_W'(dx10) * CROSS_W'(dy21);
    assign cross_rhs = CROSS_W'(dy10) * CROSS_W'(dx21);
    // clockwise winding in screen space counts as back-facing
    assign back_face = cross_lhs > cross_rhs;

    always_comb begin
        box_clip = box_in;
        // right edge limited to screen width
        if (box_in.ur.x.whole > screen.width.whole) begin
            box_clip.ur.x = screen.width;
        end
        // top edge limited to screen height
        if (box_in.ur.y.whole > screen.height.whole) begin
            box_clip.ur.y = screen.height;
        end
        // left edge raised to the origin
        if (box_in.ll.x.whole < 0) begin
            box_clip.ll.x.whole = '0;
        end
        // bottom edge raised to the origin
        if (box_in.ll.y.whole < 0) begin
            box_clip.ll.y.whole = '0;
        end
    end

    assign item.valid    = tri_valid & ~back_face;
    assign item.tri_data = tri_in;
    assign item.box      = box_clip;

endmodule

//--- bbox_pipe.sv
// Delay line of BBOX_PIPE_DEPTH item registers.
// hold high freezes every stage and drops the input item.
// No handshake, the producer must respect hold itself.

`timescale 1ns/1ps
`include "bbox_settings.svh"

module bbox_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hold,
    input  bbox_pkg::bbox_item_t item_in,
    output bbox_pkg::bbox_item_t item_out
);

    localparam int DEPTH = `BBOX_PIPE_DEPTH;

    // stage 0 is nearest the input
    bbox_pkg::bbox_item_t stage [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // valid and payload all cleared
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (!hold) begin
            stage[0] <= item_in;
            // every stage moves one step together
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // last register feeds the output directly
    assign item_out = stage[DEPTH-1];

endmodule

//--- bbox_top.sv
// Bounding-box stage top level.
// Accepts one triangle per cycle when hold is low.
// Output lags input by BBOX_PIPE_DEPTH accepted edges.
// screen and ss_code are treated as static configuration.

`timescale 1ns/1ps

module bbox_top (
    input  logic               clk,
    input  logic               rst_n,
    input  bbox_pkg::tri_t     tri_in,
    input  logic               tri_valid,
    input  bbox_pkg::screen_t  screen,
    input  bbox_pkg::ss_code_t ss_code,
    input  logic               hold,
    output bbox_pkg::tri_t     out_tri,
    output bbox_pkg::box_t     out_box,
    output logic               out_valid
);

    bbox_pkg::box_t       raw_box;
    bbox_pkg::box_t       snap_box;
    bbox_pkg::bbox_item_t clip_item;
    bbox_pkg::bbox_item_t pipe_item;

    // min and max per axis
    bbox_extent u_extent (
        .tri_in (tri_in),
        .box    (raw_box)
    );

    // floor onto the sample grid
    bbox_snap u_snap (
        .box_in  (raw_box),
        .ss_code (ss_code),
        .box_out (snap_box)
    );

    // clamp to screen, cull back faces
    bbox_clip u_clip (
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .box_in    (snap_box),
        .screen    (screen),
        .item      (clip_item)
    );

    bbox_pipe u_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .hold     (hold),
        .item_in  (clip_item),
        .item_out (pipe_item)
    );

    assign out_tri   = pipe_item.tri_data;
    assign out_box   = pipe_item.box;
    assign out_valid = pipe_item.valid;

endmodule

//--- bbox_assert.sv
// Protocol checks bound into the bounding-box top level.
// The screen check assumes screen only changes while no valid item is
// in flight, as a static configuration register would.

`timescale 1ns/1ps

module bbox_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              hold,
    input bbox_pkg::screen_t screen,
    input bbox_pkg::tri_t    out_tri,
    input bbox_pkg::box_t    out_box,
    input logic              out_valid
);

    // nothing leaves the pipe while in reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high while rst_n low");

    // a valid box never reaches past the screen or below the origin
    a_box_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_box.ur.x.whole <= screen.width.whole &&
                       out_box.ur.y.whole <= screen.height.whole &&
                       out_box.ll.x.whole >= 0 &&
                       out_box.ll.y.whole >= 0))
        else $error("valid box outside the screen");

    // a held edge loads nothing, so the next sample matches this one
    a_hold_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> ($stable(out_tri) && $stable(out_box) && $stable(out_valid)))
        else $error("outputs moved while hold was high");

endmodule

bind bbox_top bbox_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .hold      (hold),
    .screen    (screen),
    .out_tri   (out_tri),
    .out_box   (out_box),
    .out_valid (out_valid)
);

//--- tb_bbox.sv
// Testbench for the bounding-box stage, seeded random stimulus.
// A delay-line model shifts on the same edges as the DUT and is compared at
// each falling edge. screen and ss_code only change after a flush of the pipe.
// The first error stops the run.

`timescale 1ns/1ps
`include "bbox_settings.svh"

module tb_bbox;

    localparam int DEPTH      = `BBOX_PIPE_DEPTH;
    localparam int RESET_LEN  = 8;
    localparam int NUM_CYCLES = 2000;
    // cycles between configuration changes
    localparam int SEG_LEN    = 200;
    localparam int FLUSH_LEN  = DEPTH + 1;
    // reset, stimulus, flushes, final drain and some slack
    localparam int MAX_CYCLES = RESET_LEN + NUM_CYCLES + (NUM_CYCLES / SEG_LEN) * FLUSH_LEN
                                + FLUSH_LEN + 150;

    logic                 clk;
    logic                 rst_n;
    bbox_pkg::tri_t       tri_in;
    logic                 tri_valid;
    bbox_pkg::screen_t    screen;
    bbox_pkg::ss_code_t   ss_code;
    logic                 hold;
    bbox_pkg::tri_t       out_tri;
    bbox_pkg::box_t       out_box;
    logic                 out_valid;

    // model delay line, entry DEPTH-1 is what the outputs should show
    bbox_pkg::bbox_item_t model_line [DEPTH];
    int                   seed;
    int                   cycle_count;
    int                   fail_count;

    bbox_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .screen    (screen),
        .ss_code   (ss_code),
        .hold      (hold),
        .out_tri   (out_tri),
        .out_box   (out_box),
        .out_valid (out_valid)
    );

    always #10 clk = ~clk;

    task automatic stop_on_failure;
        fail_count++;
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_tri(input bbox_pkg::tri_t exp, input bbox_pkg::tri_t act);
        if (act !== exp) begin
            $display("FAIL time=%0t signal=out_tri expected=%h actual=%h", $time, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_box(input bbox_pkg::box_t exp, input bbox_pkg::box_t act);
        if (act !== exp) begin
            $display("FAIL time=%0t signal=out_box expected=%h actual=%h", $time, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL time=%0t signal=out_valid expected=%b actual=%b", $time, exp, act);
            stop_on_failure();
        end
    endtask

    // uniform integer in lo..hi
    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic bbox_pkg::coord_u to_coord(input int v);
        bbox_pkg::coord_u c;
        c.whole = v[`BBOX_SIGFIG-1:0];
        return c;
    endfunction

    // extent, floor to the sample grid, clamp per edge, back-face test
    function automatic bbox_pkg::bbox_item_t model_item(
        input bbox_pkg::tri_t     t,
        input logic               v,
        input bbox_pkg::screen_t  s,
        input bbox_pkg::ss_code_t c
    );
        bbox_pkg::bbox_item_t it;
        int     xv [3];
        int     yv [3];
        int     lo_x;
        int     lo_y;
        int     hi_x;
        int     hi_y;
        int     drop;
        longint lhs;
        longint rhs;
        for (int i = 0; i < 3; i++) begin
            xv[i] = int'(t[i].x.whole);
            yv[i] = int'(t[i].y.whole);
        end
        lo_x = xv[0];
        hi_x = xv[0];
        lo_y = yv[0];
        hi_y = yv[0];
        for (int i = 1; i < 3; i++) begin
            lo_x = (xv[i] < lo_x) ? xv[i] : lo_x;
            hi_x = (xv[i] > hi_x) ? xv[i] : hi_x;
            lo_y = (yv[i] < lo_y) ? yv[i] : lo_y;
            hi_y = (yv[i] > hi_y) ? yv[i] : hi_y;
        end
        // low fraction bits dropped, 10 minus log2 of samples per side
        case (c)
            4'b0100: drop = `BBOX_RADIX - 1;
            4'b0010: drop = `BBOX_RADIX - 2;
            4'b0001: drop = `BBOX_RADIX - 3;
            default: drop = `BBOX_RADIX;
        endcase
        // arithmetic shift pair floors toward minus infinity
        lo_x = (lo_x >>> drop) <<< drop;
        hi_x = (hi_x >>> drop) <<< drop;
        lo_y = (lo_y >>> drop) <<< drop;
        hi_y = (hi_y >>> drop) <<< drop;
        if (hi_x > int'(s.width.whole)) hi_x = int'(s.width.whole);
        if (hi_y > int'(s.height.whole)) hi_y = int'(s.height.whole);
        if (lo_x < 0) lo_x = 0;
        if (lo_y < 0) lo_y = 0;
        lhs = longint'(xv[1] - xv[0]) * longint'(yv[2] - yv[1]);
        rhs = longint'(yv[1] - yv[0]) * longint'(xv[2] - xv[1]);
        it = '0;
        it.valid = v && (lhs <= rhs);
        it.tri_data = t;
        it.box.ll.x = to_coord(lo_x);
        it.box.ll.y = to_coord(lo_y);
        it.box.ur.x = to_coord(hi_x);
        it.box.ur.y = to_coord(hi_y);
        return it;
    endfunction

    // screen of 64 to 512 pixels per side, fraction bits random too
    task automatic new_config;
        screen.width  = to_coord(rand_range(64 << `BBOX_RADIX, 512 << `BBOX_RADIX));
        screen.height = to_coord(rand_range(64 << `BBOX_RADIX, 512 << `BBOX_RADIX));
        case (rand_range(0, 3))
            0:       ss_code = 4'b1000;
            1:       ss_code = 4'b0100;
            2:       ss_code = 4'b0010;
            default: ss_code = 4'b0001;
        endcase
        // now and then any 4-bit pattern, mostly not one-hot
        if (rand_range(0, 7) == 0) begin
            ss_code = 4'(rand_range(0, 15));
        end
    endtask

    // vertices reach 64 pixels past every screen edge
    task automatic drive_triangle;
        for (int i = 0; i < 3; i++) begin
            tri_in[i].x = to_coord(rand_range(-(64 << `BBOX_RADIX),
                                              int'(screen.width.whole) + (64 << `BBOX_RADIX)));
            tri_in[i].y = to_coord(rand_range(-(64 << `BBOX_RADIX),
                                              int'(screen.height.whole) + (64 << `BBOX_RADIX)));
        end
        tri_valid = (rand_range(0, 7) != 0);
        hold      = (rand_range(0, 4) == 0);
    endtask

    // empty cycles with hold low push every real item out
    task automatic flush_pipe;
        tri_valid = 1'b0;
        hold      = 1'b0;
        repeat (FLUSH_LEN) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) model_line[i] = '0;
        end else if (!hold) begin
            for (int i = DEPTH - 1; i > 0; i--) model_line[i] = model_line[i-1];
            model_line[0] = model_item(tri_in, tri_valid, screen, ss_code);
        end
    end

    // outputs settled long before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_tri(model_line[DEPTH-1].tri_data, out_tri);
            check_box(model_line[DEPTH-1].box, out_box);
            check_valid(model_line[DEPTH-1].valid, out_valid);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycle_count);
            stop_on_failure();
        end
    end

    initial begin
        seed        = 46;
        cycle_count = 0;
        fail_count  = 0;
        clk         = 1'b0;
        rst_n       = 1'b1;
        hold        = 1'b0;
        tri_valid   = 1'b0;
        tri_in      = '0;
        screen      = '0;
        ss_code     = 4'b1000;
        // clean falling edge so the asynchronous clear fires
        #1 rst_n = 1'b0;
        new_config();
        repeat (RESET_LEN) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            if (n % SEG_LEN == 0) begin
                flush_pipe();
                new_config();
            end
            drive_triangle();
            @(posedge clk);
            #1;
        end
        flush_pipe();
        @(negedge clk);
        #1;
        if (fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

//--- bbox.f
+incdir+.
bbox_pkg.sv
bbox_extent.sv
bbox_snap.sv
bbox_clip.sv
bbox_pipe.sv
bbox_top.sv
bbox_assert.sv
tb_bbox.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_bbox
FILELIST = bbox.f

BUILD    = obj_dir
SIM_BIN  = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) bbox_settings.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
